//--- rtl/rv_isa_pkg.sv
/*
 * RV32I instruction set definitions
 * Major opcodes, funct3 codes, operand source selects and the
 * instruction word with its R-type, I-type and branch/jump views
 */
package rv_isa_pkg;

  localparam int XLEN = 32;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111
  } opcode_e;

  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } f3_alu_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } f3_branch_e;

  typedef enum logic [1:0] {
    REG  = 2'd0,
    IMM  = 2'd1,
    ZERO = 2'd2,
    PC   = 2'd3
  } src_sel_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_view_t;

  // B and J immediates share the sign and bits 10:5
  typedef struct packed {
    logic       imm_sign;
    logic [5:0] imm_10_5;
    logic [3:0] j_imm_4_1;
    logic       j_imm_11;
    logic [7:0] j_imm_19_12;
    logic [3:0] b_imm_4_1;
    logic       b_imm_11;
    opcode_e    opcode;
  } b_view_t;

  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    b_view_t b_view;
  } instr_u;

endpackage

//--- rtl/core_pipe_pkg.sv
/*
 * Core pipeline types
 * Register widths and the structs passed between decode,
 * execute, writeback and the fetch redirect path
 */
package core_pipe_pkg;
  import rv_isa_pkg::*;

  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  typedef logic [REG_AW-1:0] raddr_t;
  typedef logic [XLEN-1:0]   word_t;

  typedef struct packed {
    logic       valid;
    word_t      pc;
    raddr_t     rs1_addr;
    raddr_t     rs2_addr;
    raddr_t     rd_addr;
    logic       we_rd;
    src_sel_e   rs1_sel;
    src_sel_e   rs2_sel;
    word_t      imm;
    logic [2:0] f3;
    logic       alt;
    logic       branch;
    logic       jump;
    logic       jalr;
  } id_ex_t;

  typedef struct packed {
    logic   valid;
    raddr_t rd_addr;
    logic   we_rd;
    word_t  result;
  } ex_wb_t;

  typedef struct packed {
    logic  req;
    word_t addr;
  } redirect_t;

endpackage

//--- rtl/decode.sv
/*
 * Decode stage
 * Registers each accepted instruction and cracks it into
 * operand selects, immediate, ALU function and control flags
 */
module decode
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   stall_i,
  input  logic   instr_valid_i,
  input  instr_u instr_i,
  input  word_t  pc_i,
  input  logic   flush_i,
  output id_ex_t id_ex_o
);
  id_ex_t id_ex_q;
  id_ex_t dec;
  word_t  imm_i, imm_b, imm_j, imm_u;

  assign imm_i = {{20{instr_i.i_view.imm[11]}}, instr_i.i_view.imm};
  assign imm_u = {instr_i.i_view.imm, instr_i.i_view.rs1, instr_i.i_view.funct3, 12'h000};
  assign imm_b = {{19{instr_i.b_view.imm_sign}}, instr_i.b_view.imm_sign,
                  instr_i.b_view.b_imm_11, instr_i.b_view.imm_10_5,
                  instr_i.b_view.b_imm_4_1, 1'b0};
  assign imm_j = {{11{instr_i.b_view.imm_sign}}, instr_i.b_view.imm_sign,
                  instr_i.b_view.j_imm_19_12, instr_i.b_view.j_imm_11,
                  instr_i.b_view.imm_10_5, instr_i.b_view.j_imm_4_1, 1'b0};

  always_comb begin
    dec          = '0;
    dec.valid    = instr_valid_i;
    dec.pc       = pc_i;
    dec.rs1_addr = instr_i.r_view.rs1;
    dec.rs2_addr = instr_i.r_view.rs2;
    dec.rd_addr  = instr_i.r_view.rd;
    dec.f3       = instr_i.r_view.funct3;
    dec.rs1_sel  = REG;
    dec.rs2_sel  = REG;
    case (instr_i.r_view.opcode)
      OP: begin
        dec.we_rd = 1'b1;
        dec.alt   = instr_i.r_view.funct7[5];
      end
      OP_IMM: begin
        dec.we_rd   = 1'b1;
        dec.rs2_sel = IMM;
        dec.imm     = imm_i;
        // Bit 30 only selects SRAI, elsewhere it is immediate
        dec.alt     = (instr_i.r_view.funct3 == SRL_SRA) && instr_i.r_view.funct7[5];
      end
      LUI: begin
        dec.we_rd   = 1'b1;
        dec.rs1_sel = ZERO;
        dec.rs2_sel = IMM;
        dec.imm     = imm_u;
        dec.f3      = ADD_SUB;
      end
      BRANCH: begin
        dec.branch = 1'b1;
        dec.imm    = imm_b;
      end
      JAL: begin
        dec.we_rd   = 1'b1;
        dec.jump    = 1'b1;
        dec.rs1_sel = PC;
        dec.rs2_sel = IMM;
        dec.imm     = imm_j;
        dec.f3      = ADD_SUB;
      end
      JALR: begin
        dec.we_rd   = 1'b1;
        dec.jump    = 1'b1;
        dec.jalr    = 1'b1;
        dec.rs2_sel = IMM;
        dec.imm     = imm_i;
        dec.f3      = ADD_SUB;
      end
      default: ;
    endcase
    if (dec.rd_addr == '0) begin
      dec.we_rd = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_ex_q <= '0;
    end else if (!stall_i) begin
      id_ex_q <= flush_i ? id_ex_t'('0) : dec;
    end
  end

  assign id_ex_o = id_ex_q;

endmodule

//--- rtl/regfile.sv
/*
 * Integer register file
 * 31 writable registers, two combinational read ports and one
 * write port fed from the execute result register
 */
module regfile
  import core_pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  raddr_t rs1_addr_i,
  input  raddr_t rs2_addr_i,
  output word_t  rs1_data_o,
  output word_t  rs2_data_o,
  input  ex_wb_t wr_i
);
  word_t regs_q [NUM_REGS-1:1];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.valid && wr_i.we_rd && (wr_i.rd_addr != '0)) begin
      regs_q[wr_i.rd_addr] <= wr_i.result;
    end
  end

  // x0 is hardwired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

//--- rtl/execute.sv
/*
 * Execute stage
 * Operand selection with forwarding, ALU, branch and jump
 * evaluation, result register and registered fetch redirect
 */
module execute
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      stall_i,
  input  id_ex_t    id_ex_i,
  input  word_t     rs1_data_i,
  input  word_t     rs2_data_i,
  output ex_wb_t    ex_wb_o,
  output redirect_t redirect_o
);
  ex_wb_t    ex_wb_q, ex_wb_d;
  redirect_t redirect_q, redirect_d;
  word_t     op_a, op_b, alu_res, jump_tgt;
  logic      fwd_a, fwd_b;
  logic      take_branch;
  logic      squash;

  function automatic word_t src_mux(src_sel_e sel, word_t rdata, word_t imm, word_t pc);
    word_t val;
    case (sel)
      REG:     val = rdata;
      IMM:     val = imm;
      ZERO:    val = '0;
      PC:      val = pc;
      default: val = '0;
    endcase
    return val;
  endfunction

  function automatic logic branch_taken(f3_branch_e f3, word_t a, word_t b);
    logic taken;
    case (f3)
      BEQ:     taken = (a == b);
      BNE:     taken = (a != b);
      BLT:     taken = ($signed(a) < $signed(b));
      BGE:     taken = ($signed(a) >= $signed(b));
      BLTU:    taken = (a < b);
      BGEU:    taken = (a >= b);
      default: taken = 1'b0;
    endcase
    return taken;
  endfunction

  // Redirect cycle kills the instruction in the shadow slot
  assign squash = redirect_q.req;

  assign fwd_a = ex_wb_q.we_rd && (id_ex_i.rs1_sel == REG) &&
                 (ex_wb_q.rd_addr == id_ex_i.rs1_addr);
  assign fwd_b = ex_wb_q.we_rd && (id_ex_i.rs2_sel == REG) &&
                 (ex_wb_q.rd_addr == id_ex_i.rs2_addr);

  assign op_a = fwd_a ? ex_wb_q.result :
                src_mux(id_ex_i.rs1_sel, rs1_data_i, id_ex_i.imm, id_ex_i.pc);
  assign op_b = fwd_b ? ex_wb_q.result :
                src_mux(id_ex_i.rs2_sel, rs2_data_i, id_ex_i.imm, id_ex_i.pc);

  always_comb begin
    case (f3_alu_e'(id_ex_i.f3))
      ADD_SUB: alu_res = id_ex_i.alt ? (op_a - op_b) : (op_a + op_b);
      SLL:     alu_res = op_a << op_b[4:0];
      SLT:     alu_res = word_t'($signed(op_a) < $signed(op_b));
      SLTU:    alu_res = word_t'(op_a < op_b);
      XOR:     alu_res = op_a ^ op_b;
      SRL_SRA: alu_res = id_ex_i.alt ? word_t'($signed(op_a) >>> op_b[4:0]) :
                                       (op_a >> op_b[4:0]);
      OR:      alu_res = op_a | op_b;
      AND:     alu_res = op_a & op_b;
      default: alu_res = '0;
    endcase
  end

  assign take_branch = id_ex_i.branch && branch_taken(f3_branch_e'(id_ex_i.f3), op_a, op_b);
  assign jump_tgt    = id_ex_i.jalr ? {alu_res[XLEN-1:1], 1'b0} : alu_res;

  always_comb begin
    ex_wb_d.valid   = id_ex_i.valid && !squash;
    ex_wb_d.rd_addr = id_ex_i.rd_addr;
    ex_wb_d.we_rd   = id_ex_i.valid && id_ex_i.we_rd && !squash;
    // Link address for jumps
    ex_wb_d.result  = id_ex_i.jump ? (id_ex_i.pc + word_t'(4)) : alu_res;

    redirect_d.req  = id_ex_i.valid && !squash && (id_ex_i.jump || take_branch);
    redirect_d.addr = id_ex_i.jump ? jump_tgt : (id_ex_i.pc + id_ex_i.imm);
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_wb_q    <= '0;
      redirect_q <= '0;
    end else if (!stall_i) begin
      ex_wb_q    <= ex_wb_d;
      redirect_q <= redirect_d;
    end
  end

  assign ex_wb_o = ex_wb_q;

  // A held redirect fires once the stall drops
  assign redirect_o.req  = redirect_q.req && !stall_i;
  assign redirect_o.addr = redirect_q.addr;

endmodule

//--- rtl/ex_core_top.sv
/*
 * Integer core top level
 * Connects decode, register file and execute, and exposes the
 * retired writes and the fetch redirect
 */
module ex_core_top
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   stall_i,
  input  logic   instr_valid_i,
  input  instr_u instr_i,
  input  word_t  pc_i,
  output logic   instr_ready_o,
  output logic   wb_valid_o,
  output raddr_t wb_rd_o,
  output word_t  wb_data_o,
  output logic   fetch_req_o,
  output word_t  fetch_addr_o
);
  id_ex_t    id_ex;
  ex_wb_t    ex_wb;
  redirect_t redirect;
  word_t     rs1_data, rs2_data;

  decode u_decode (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .flush_i       (redirect.req),
    .id_ex_o       (id_ex)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (id_ex.rs1_addr),
    .rs2_addr_i (id_ex.rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_i       (ex_wb)
  );

  execute u_execute (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .stall_i    (stall_i),
    .id_ex_i    (id_ex),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .ex_wb_o    (ex_wb),
    .redirect_o (redirect)
  );

  assign instr_ready_o = ~stall_i;

  // we_rd is only set for valid, unsquashed writes
  assign wb_valid_o   = ex_wb.we_rd;
  assign wb_rd_o      = ex_wb.rd_addr;
  assign wb_data_o    = ex_wb.result;
  assign fetch_req_o  = redirect.req;
  assign fetch_addr_o = redirect.addr;

endmodule

//--- verif/tb_clk_gen.sv
/*
 * Testbench clock source
 * Free running 20 ns clock
 */
module tb_clk_gen (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

//--- verif/ex_core_props.sv
/*
 * Property checker for the integer core
 * Bound into the top level, watches stall behavior, writes
 * to x0 and the single cycle fetch redirect
 */
module ex_core_props
  import core_pipe_pkg::*;
(
  input logic   clk,
  input logic   rst_n_i,
  input logic   stall_i,
  input logic   wb_valid_i,
  input raddr_t wb_rd_i,
  input word_t  wb_data_i,
  input logic   fetch_req_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // A stalled edge leaves the retired write in place
  stall_holds_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
    stall_i |=> $stable(wb_valid_i) && $stable(wb_rd_i) && $stable(wb_data_i))
    else begin
      fail_cnt++;
      $error("wb outputs changed across a stalled edge");
    end

  redirect_one_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    fetch_req_i |=> !fetch_req_i)
    else begin
      fail_cnt++;
      $error("fetch request high in two consecutive cycles");
    end

  // x0 is never a write target
  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_valid_i |-> wb_rd_i != '0)
    else begin
      fail_cnt++;
      $error("retired write to x0");
    end

endmodule

//--- verif/tb_ex_core.sv
/*
 * Testbench for the integer core
 * Random RV32I stream with random stalls, checked against an
 * architectural register model and expected branch targets
 */
module tb_ex_core
  import rv_isa_pkg::*;
  import core_pipe_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_INSTR    = 400;
  localparam int CLK_PERIOD = 20;

  logic   clk, rst_n, stall, instr_valid;
  instr_u instr;
  word_t  pc;
  logic   instr_ready, wb_valid, fetch_req;
  raddr_t wb_rd;
  word_t  wb_data, fetch_addr;

  // Architectural model
  word_t  xreg [NUM_REGS];
  word_t  model_pc, shadow_tgt;
  int     skip, issued;
  bit     advanced;
  raddr_t exp_rd [$];
  word_t  exp_data [$];
  word_t  exp_tgt [$];

  tb_clk_gen u_clk_gen (.clk_o(clk));

  ex_core_top u_ex_core_top (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .stall_i       (stall),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .instr_ready_o (instr_ready),
    .wb_valid_o    (wb_valid),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .fetch_req_o   (fetch_req),
    .fetch_addr_o  (fetch_addr)
  );

  bind ex_core_top ex_core_props u_ex_core_props (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .stall_i       (stall_i),
    .wb_valid_i    (wb_valid_o),
    .wb_rd_i       (wb_rd_o),
    .wb_data_i     (wb_data_o),
    .fetch_req_i   (fetch_req_o)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_wb(input raddr_t rd, input word_t data);
    raddr_t e_rd;
    word_t  e_data;
    if (exp_rd.size() == 0) begin
      fail_run($sformatf("unexpected retirement of x%0d = %h", rd, data));
    end else begin
      e_rd   = exp_rd.pop_front();
      e_data = exp_data.pop_front();
      if (rd !== e_rd || data !== e_data) begin
        fail_run($sformatf("mismatch wb_retire expected x%0d=%h actual x%0d=%h",
                           e_rd, e_data, rd, data));
      end
    end
  endtask

  task automatic check_redirect(input word_t addr);
    word_t e_addr;
    if (exp_tgt.size() == 0) begin
      fail_run($sformatf("fetch request to %h with no taken branch or jump", addr));
    end else begin
      e_addr = exp_tgt.pop_front();
      if (addr !== e_addr) begin
        fail_run($sformatf("mismatch redirect expected %h actual %h", e_addr, addr));
      end
    end
  endtask

  // Ready is the inverse of the stall level
  task automatic check_ready(input logic ready);
    if (ready !== !stall) begin
      fail_run($sformatf("mismatch instr_ready expected %b actual %b", !stall, ready));
    end
  endtask

  task automatic check_idle();
    if (wb_valid !== 1'b0 || fetch_req !== 1'b0) begin
      fail_run("write or fetch request seen before any instruction was issued");
    end
  endtask

  function automatic word_t model_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic model_taken(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Mostly a small window so results feed later operands
  function automatic raddr_t pick_reg();
    if ($urandom_range(0, 3) == 0) begin
      return raddr_t'($urandom_range(0, 31));
    end
    return raddr_t'($urandom_range(0, 7));
  endfunction

  task automatic issue_next();
    instr_u     ins;
    int         kind;
    raddr_t     rs1, rs2, rd;
    logic [2:0] f3;
    logic       alt, wr, taken;
    word_t      r, imm, a, b, res, tgt;
    ins   = '0;
    kind  = $urandom_range(0, 12);
    r     = $urandom();
    rs1   = pick_reg();
    rs2   = pick_reg();
    rd    = pick_reg();
    f3    = 3'($urandom_range(0, 7));
    alt   = 1'b0;
    wr    = 1'b1;
    taken = 1'b0;
    a     = xreg[rs1];
    b     = xreg[rs2];
    imm   = '0;
    res   = '0;
    tgt   = '0;
    ins.r_view.rs1    = rs1;
    ins.r_view.rs2    = rs2;
    ins.r_view.rd     = rd;
    ins.r_view.funct3 = f3;
    if (kind <= 4) begin
      alt = (f3 == 3'd0 || f3 == 3'd5) && r[30];
      ins.r_view.opcode = OP;
      ins.r_view.funct7 = {1'b0, alt, 5'b00000};
      res = model_alu(f3, alt, a, b);
    end else if (kind <= 7) begin
      ins.r_view.opcode = OP_IMM;
      if (f3 == 3'd1 || f3 == 3'd5) begin
        alt = (f3 == 3'd5) && r[30];
        imm = {27'd0, r[4:0]};
        ins.i_view.imm = {1'b0, alt, 5'b00000, r[4:0]};
      end else begin
        imm = {{20{r[11]}}, r[11:0]};
        ins.i_view.imm = r[11:0];
      end
      res = model_alu(f3, alt, a, imm);
    end else if (kind == 8) begin
      imm = {r[31:12], 12'h000};
      ins.r_view.opcode = LUI;
      ins.i_view.imm    = imm[31:20];
      ins.i_view.rs1    = imm[19:15];
      ins.i_view.funct3 = imm[14:12];
      res = imm;
    end else if (kind <= 10) begin
      // funct3 2 and 3 are not branches
      if (f3 == 3'd2 || f3 == 3'd3) begin
        f3 = f3 + 3'd4;
      end
      wr  = 1'b0;
      imm = {{19{r[12]}}, r[12:1], 1'b0};
      ins.r_view.opcode    = BRANCH;
      ins.r_view.funct3    = f3;
      ins.b_view.imm_sign  = imm[12];
      ins.b_view.imm_10_5  = imm[10:5];
      ins.b_view.b_imm_4_1 = imm[4:1];
      ins.b_view.b_imm_11  = imm[11];
      taken = model_taken(f3, a, b);
      tgt   = model_pc + imm;
    end else if (kind == 11) begin
      imm = {{11{r[20]}}, r[20:1], 1'b0};
      ins.r_view.opcode      = JAL;
      ins.b_view.imm_sign    = imm[20];
      ins.b_view.imm_10_5    = imm[10:5];
      ins.b_view.j_imm_4_1   = imm[4:1];
      ins.b_view.j_imm_11    = imm[11];
      ins.b_view.j_imm_19_12 = imm[19:12];
      taken = 1'b1;
      tgt   = model_pc + imm;
      res   = model_pc + 32'd4;
    end else begin
      imm = {{20{r[11]}}, r[11:0]};
      ins.r_view.opcode = JALR;
      ins.r_view.funct3 = 3'd0;
      ins.i_view.imm    = r[11:0];
      taken = 1'b1;
      tgt   = (a + imm) & ~32'd1;
      res   = model_pc + 32'd4;
    end
    instr       = ins;
    pc          = model_pc;
    instr_valid = 1'b1;
    issued++;
    // The two slots behind a taken branch or jump are discarded
    if (skip > 0) begin
      skip--;
      model_pc = (skip == 0) ? shadow_tgt : model_pc + 32'd4;
    end else begin
      if (wr && rd != '0) begin
        xreg[rd] = res;
        exp_rd.push_back(rd);
        exp_data.push_back(res);
      end
      if (taken) begin
        exp_tgt.push_back(tgt);
        skip       = 2;
        shadow_tgt = tgt;
      end
      model_pc = model_pc + 32'd4;
    end
  endtask

  task automatic issue_bubble();
    instr_valid = 1'b0;
    if (skip > 0) begin
      skip--;
    end
  endtask

  // Check what the last edge produced, then drive the next cycle
  task automatic step(input bit issue);
    @(negedge clk);
    if (advanced && wb_valid) begin
      check_wb(wb_rd, wb_data);
    end
    stall    = ($urandom_range(0, 3) == 0);
    advanced = !stall;
    if (!stall) begin
      if (issue) begin
        issue_next();
      end else begin
        issue_bubble();
      end
    end
    #(CLK_PERIOD / 4);
    check_ready(instr_ready);
    if (fetch_req) begin
      check_redirect(fetch_addr);
    end
  endtask

  initial begin
    void'($urandom(32'h530a));
    rst_n       = 1'b0;
    stall       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    advanced    = 1'b0;
    issued      = 0;
    skip        = 0;
    shadow_tgt  = '0;
    model_pc    = $urandom() & 32'hffff_fffc;
    foreach (xreg[i]) begin
      xreg[i] = '0;
    end
    repeat (16) begin
      @(posedge clk);
    end
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    while (issued < N_INSTR) begin
      step(1'b1);
    end
    while (exp_rd.size() != 0 || exp_tgt.size() != 0) begin
      step(1'b0);
    end
    repeat (4) begin
      step(1'b0);
    end
    if (u_ex_core_top.u_ex_core_props.fail_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_run($sformatf("property checker reported %0d failures",
                         u_ex_core_top.u_ex_core_props.fail_cnt));
    end
  end

  initial begin
    #(N_INSTR * 4 * CLK_PERIOD);
    fail_run("watchdog expired before all instructions retired");
  end

endmodule

//--- all.f
rtl/rv_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/decode.sv
rtl/regfile.sv
rtl/execute.sv
rtl/ex_core_top.sv
verif/tb_clk_gen.sv
verif/ex_core_props.sv
verif/tb_ex_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ex_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
